/* files.f */
hw/icache_pkg.sv
hw/icache_lookup.sv
hw/icache_miss_queue.sv
hw/icache_fill.sv
hw/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_asserts.sv
testbench/icache_tb.sv

/* testbench/icache_tb.sv */
// icache testbench: clock, reset, request counters, directed tests, compare tasks, summary
module icache_tb;

    localparam int timeout_cycles = 100;

    logic                  clock;
    logic                  reset;
    logic                  restore;
    logic                  hold;
    icache_pkg::addr_t     [icache_pkg::fetch_width-1:0] fetch_addr;
    icache_pkg::word_t     [icache_pkg::fetch_width-1:0] fetch_data;
    logic                  [icache_pkg::fetch_width-1:0] fetch_miss;
    icache_pkg::mem_req_t  mem_req;
    logic                  mem_accepted;
    icache_pkg::mem_tag_t  mem_tag;
    icache_pkg::mem_resp_t mem_resp;
    logic                  mem_idle;

    // accepted requests per block, indexed by block address bits 8 to 3
    int unsigned accept_count [64];
    logic        accept_prior [64];
    int unsigned mismatches;
    int unsigned timeouts;

    icache_top i_dut (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .mem_accepted (mem_accepted),
        .mem_tag      (mem_tag),
        .mem_resp     (mem_resp),
        .restore      (restore),
        .fetch_data   (fetch_data),
        .fetch_miss   (fetch_miss),
        .mem_req      (mem_req)
    );

    icache_mem_model i_mem (
        .clock        (clock),
        .reset        (reset),
        .mem_req      (mem_req),
        .hold         (hold),
        .mem_accepted (mem_accepted),
        .mem_tag      (mem_tag),
        .mem_resp     (mem_resp),
        .idle         (mem_idle)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        if (mem_req.valid && mem_accepted) begin
            accept_count[mem_req.addr[8:3]] <= accept_count[mem_req.addr[8:3]] + 1;
            accept_prior[mem_req.addr[8:3]] <= mem_req.prior;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // instruction word rule of the memory
    function automatic icache_pkg::word_t expected_word(icache_pkg::addr_t addr);
        return addr ^ {16'hc0de, 16'h0000};
    endfunction

    function automatic int unsigned accepts(icache_pkg::addr_t addr);
        return accept_count[addr[8:3]];
    endfunction

    function automatic logic prior_of(icache_pkg::addr_t addr);
        return accept_prior[addr[8:3]];
    endfunction

    // two consecutive words from addr
    task automatic drive_fetch(icache_pkg::addr_t addr);
        fetch_addr[0] = addr;
        fetch_addr[1] = addr + 32'd4;
    endtask

    task automatic check_word(string test, icache_pkg::word_t exp, icache_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", test, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_addr(string test, icache_pkg::addr_t exp, icache_pkg::addr_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", test, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_bit(string test, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", test, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_flags(string test, logic [icache_pkg::fetch_width-1:0] exp,
                               logic [icache_pkg::fetch_width-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", test, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_count(string test, int unsigned exp, int unsigned act);
        if (act != exp) begin
            $display("** Error %s: expected %0d, actual %0d", test, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_fetch(string test, icache_pkg::addr_t addr);
        check_word(test, expected_word(addr), fetch_data[0]);
        check_word(test, expected_word(addr + 32'd4), fetch_data[1]);
    endtask

    // both fetch slots hit
    task automatic wait_hit(string test);
        int n;
        n = 0;
        while (fetch_miss !== '0 && n < timeout_cycles) begin
            @(negedge clock);
            n++;
        end
        if (fetch_miss !== '0) begin
            $display("%s: timed out waiting for both fetch slots to hit", test);
            timeouts++;
        end
    endtask

    // no request pending and nothing left in the memory
    task automatic wait_quiet(string test);
        int n;
        n = 0;
        while (!(mem_req.valid === 1'b0 && mem_idle === 1'b1) && n < timeout_cycles) begin
            @(negedge clock);
            n++;
        end
        if (!(mem_req.valid === 1'b0 && mem_idle === 1'b1)) begin
            $display("%s: timed out waiting for the memory side to go quiet", test);
            timeouts++;
        end
    endtask

    task automatic wait_accepts(string test, icache_pkg::addr_t addr, int unsigned count);
        int n;
        n = 0;
        while (accepts(addr) < count && n < timeout_cycles) begin
            @(negedge clock);
            n++;
        end
        if (accepts(addr) < count) begin
            $display("%s: timed out waiting for a request to block %h", test, addr);
            timeouts++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    // all lines invalid and the memory bus silent while reset holds
    task automatic after_reset_state();
        check_flags("after_reset", 2'b11, fetch_miss);
        check_bit("after_reset", 1'b0, mem_req.valid);
    endtask

    task automatic cold_miss();
        // block 0 went out on the first edge, the next window block follows
        @(negedge clock);
        check_count("cold_miss", 1, accepts(32'h0000_0000));
        check_bit("cold_miss", 1'b1, mem_req.valid);
        check_bit("cold_miss", 1'b0, mem_req.prior);
        check_addr("cold_miss", 32'h0000_0008, mem_req.addr);
        wait_hit("cold_miss");
        check_fetch("cold_miss", 32'h0000_0000);
        wait_quiet("cold_miss");
        check_count("cold_miss", 1, accepts(32'h0000_0000));
    endtask

    // slot 0 in bank 1, slot 1 in bank 0
    task automatic two_bank_fetch();
        drive_fetch(32'h0000_002c);
        @(negedge clock);
        wait_hit("two_banks");
        check_fetch("two_banks", 32'h0000_002c);
        wait_quiet("two_banks");
        check_count("two_banks", 1, accepts(32'h0000_0028));
        check_count("two_banks", 1, accepts(32'h0000_0030));
        check_flags("two_banks", 2'b11, {prior_of(32'h0000_0028), prior_of(32'h0000_0030)});
    endtask

    task automatic prefetch_window();
        drive_fetch(32'h0000_0050);
        @(negedge clock);
        wait_hit("prefetch");
        wait_quiet("prefetch");
        // later blocks of the window hit at once
        drive_fetch(32'h0000_0058);
        @(negedge clock);
        check_flags("prefetch", 2'b00, fetch_miss);
        check_fetch("prefetch", 32'h0000_0058);
        drive_fetch(32'h0000_0060);
        @(negedge clock);
        check_flags("prefetch", 2'b00, fetch_miss);
        check_fetch("prefetch", 32'h0000_0060);
        wait_quiet("prefetch");
        check_count("prefetch", 1, accepts(32'h0000_0050));
        check_count("prefetch", 1, accepts(32'h0000_0058));
        check_count("prefetch", 1, accepts(32'h0000_0060));
    endtask

    task automatic in_flight_dedup();
        hold = 1'b1;
        drive_fetch(32'h0000_0080);
        @(negedge clock);
        wait_accepts("in_flight", 32'h0000_0090, 1);
        // one MSHR left, only the block past the old window may go out
        drive_fetch(32'h0000_0088);
        @(negedge clock);
        wait_accepts("in_flight", 32'h0000_0098, 1);
        check_count("in_flight", 1, accepts(32'h0000_0080));
        check_count("in_flight", 1, accepts(32'h0000_0088));
        check_count("in_flight", 1, accepts(32'h0000_0090));
        hold = 1'b0;
        wait_hit("in_flight");
        check_fetch("in_flight", 32'h0000_0088);
        wait_quiet("in_flight");
        check_count("in_flight", 1, accepts(32'h0000_0088));
    endtask

    task automatic restore_abandon();
        hold = 1'b1;
        drive_fetch(32'h0000_00a0);
        @(negedge clock);
        wait_accepts("restore", 32'h0000_00b0, 1);
        // park on cached blocks and drop the three misses
        drive_fetch(32'h0000_0088);
        restore = 1'b1;
        @(negedge clock);
        restore = 1'b0;
        hold    = 1'b0;
        // stale responses drain here
        wait_quiet("restore");
        drive_fetch(32'h0000_00a0);
        @(negedge clock);
        check_flags("restore", 2'b11, fetch_miss);
        wait_hit("restore");
        check_fetch("restore", 32'h0000_00a0);
        wait_quiet("restore");
        check_count("restore", 2, accepts(32'h0000_00a0));
    endtask

    initial begin
        void'($urandom(32'hde03));
        clock        = 1'b0;
        reset        = 1'b1;
        restore      = 1'b0;
        hold         = 1'b0;
        mismatches   = 0;
        timeouts     = 0;
        foreach (accept_count[i]) begin
            accept_count[i] = 0;
            accept_prior[i] = 1'b0;
        end
        drive_fetch(32'h0000_0000);
        repeat (3) @(negedge clock);
        after_reset_state();
        reset = 1'b0;

        cold_miss();
        two_bank_fetch();
        prefetch_window();
        in_flight_dedup();
        restore_abandon();

        $display("summary: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, i_dut.i_asserts.failures);
        if (mismatches == 0 && timeouts == 0 && i_dut.i_asserts.failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/icache_asserts.sv */
// concurrent assertions on the memory protocol and the fetch outputs, with their bind
module icache_asserts (
    input logic                 clock,
    input logic                 reset,
    input icache_pkg::mem_req_t mem_req,
    input logic                 mem_accepted,
    input icache_pkg::mem_tag_t mem_tag,
    input icache_pkg::word_t    [icache_pkg::fetch_width-1:0] fetch_data,
    input logic                 [icache_pkg::fetch_width-1:0] fetch_miss
);

    int unsigned failures = 0;

    // an accepted request always carries a real tag
    assert property (@(posedge clock) disable iff (reset) mem_accepted |-> (mem_tag != '0))
        else begin
            $error("memory accepted a request with tag 0");
            failures++;
        end

    // nothing goes to memory during reset
    assert property (@(posedge clock) reset |-> !mem_req.valid)
        else begin
            $error("request raised while reset was high");
            failures++;
        end

    // a hit slot carries known data
    for (genvar i = 0; i < icache_pkg::fetch_width; i++) begin : g_slot
        assert property (@(posedge clock) disable iff (reset)
                !fetch_miss[i] |-> !$isunknown(fetch_data[i]))
            else begin
                $error("fetch slot %0d hits with unknown data", i);
                failures++;
            end
    end

endmodule

bind icache_top icache_asserts i_asserts (
    .clock        (clock),
    .reset        (reset),
    .mem_req      (mem_req),
    .mem_accepted (mem_accepted),
    .mem_tag      (mem_tag),
    .fetch_data   (fetch_data),
    .fetch_miss   (fetch_miss)
);

/* testbench/icache_mem_model.sv */
// memory model with same-cycle accept and fresh tags, in-order responses, data from an address rule
module icache_mem_model (
    input  logic                  clock,
    input  logic                  reset,
    input  icache_pkg::mem_req_t  mem_req,
    input  logic                  hold,
    output logic                  mem_accepted,
    output icache_pkg::mem_tag_t  mem_tag,
    output icache_pkg::mem_resp_t mem_resp,
    output logic                  idle
);

    // one accepted block waiting for its response
    typedef struct packed {
        icache_pkg::addr_t    addr;
        icache_pkg::mem_tag_t tag;
        int unsigned          due;
    } pending_t;

    pending_t             pending [$];
    int unsigned          cycle;
    icache_pkg::mem_tag_t next_tag;

    // word content follows the address
    function automatic icache_pkg::word_t word_at(icache_pkg::addr_t addr);
        return addr ^ {16'hc0de, 16'h0000};
    endfunction

    function automatic logic tag_in_use(icache_pkg::mem_tag_t tag);
        foreach (pending[i]) begin
            if (pending[i].tag == tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // random nonzero tag not held by any outstanding block
    function automatic icache_pkg::mem_tag_t pick_tag();
        int unsigned          start;
        icache_pkg::mem_tag_t cand;
        start = $urandom_range(14, 0);
        for (int k = 0; k < 15; k++) begin
            cand = icache_pkg::mem_tag_t'((start + k) % 15 + 1);
            if (!tag_in_use(cand)) begin
                return cand;
            end
        end
        return '0;
    endfunction

    // every request is taken once reset is gone
    assign mem_accepted = mem_req.valid && !reset;
    assign mem_tag      = next_tag;

    always @(posedge clock) begin
        pending_t entry;
        logic     sent;
        if (reset) begin
            pending.delete();
            cycle = 0;
            mem_resp <= '0;
            next_tag <= 4'd1;
            idle     <= 1'b1;
        end else begin
            cycle = cycle + 1;
            sent  = 1'b0;
            if (mem_accepted) begin
                entry.addr = mem_req.addr;
                entry.tag  = mem_tag;
                entry.due  = cycle + $urandom_range(12, 3);
                pending.push_back(entry);
            end
            // strictly in order, the cache only matches its oldest MSHR
            if (!hold && pending.size() != 0 && cycle >= pending[0].due) begin
                entry = pending.pop_front();
                sent  = 1'b1;
                mem_resp.tag  <= entry.tag;
                mem_resp.data <= {word_at(entry.addr + 32'd4), word_at(entry.addr)};
            end else begin
                mem_resp <= '0;
            end
            next_tag <= pick_tag();
            // quiet once the last response has been taken by the cache
            idle <= (pending.size() == 0) && !sent;
        end
    end

endmodule

/* hw/icache_top.sv */
// icache top level wiring lookup, miss queue and fill
module icache_top (
    input  logic                 clock,
    input  logic                 reset,
    input  icache_pkg::addr_t    [icache_pkg::fetch_width-1:0] fetch_addr,
    input  logic                 mem_accepted,
    input  icache_pkg::mem_tag_t mem_tag,
    input  icache_pkg::mem_resp_t mem_resp,
    input  logic                 restore,
    output icache_pkg::word_t    [icache_pkg::fetch_width-1:0] fetch_data,
    output logic                 [icache_pkg::fetch_width-1:0] fetch_miss,
    output icache_pkg::mem_req_t mem_req
);

    // lookup to fill and queue
    icache_pkg::line_meta_t [icache_pkg::num_banks-1:0][icache_pkg::num_sets-1:0] line_meta;
    icache_pkg::block_t     [icache_pkg::num_banks-1:0]     read_block;
    icache_pkg::set_idx_t   [icache_pkg::num_banks-1:0]     read_set;
    icache_pkg::addr_t      [icache_pkg::prefetch_dist-1:0] window_addr;
    logic                   [icache_pkg::prefetch_dist-1:0] cache_miss_window;

    // queue and fill handshake
    icache_pkg::mshr_entry_t head_entry;
    logic                    queue_empty;
    logic                    fill_done;

    icache_lookup i_lookup (
        .fetch_addr        (fetch_addr),
        .line_meta         (line_meta),
        .read_block        (read_block),
        .window_addr       (window_addr),
        .cache_miss_window (cache_miss_window),
        .read_set          (read_set),
        .fetch_data        (fetch_data),
        .fetch_miss        (fetch_miss)
    );

    icache_miss_queue i_miss_queue (
        .clock             (clock),
        .reset             (reset),
        .window_addr       (window_addr),
        .cache_miss_window (cache_miss_window),
        .mem_accepted      (mem_accepted),
        .mem_tag           (mem_tag),
        .restore           (restore),
        .fill_done         (fill_done),
        .mem_req           (mem_req),
        .head_entry        (head_entry),
        .queue_empty       (queue_empty)
    );

    icache_fill i_fill (
        .clock       (clock),
        .reset       (reset),
        .mem_resp    (mem_resp),
        .head_entry  (head_entry),
        .queue_empty (queue_empty),
        .read_set    (read_set),
        .line_meta   (line_meta),
        .read_block  (read_block),
        .fill_done   (fill_done)
    );

endmodule

/* hw/icache_fill.sv */
// icache fill: per-bank data and metadata arrays, response match against the oldest MSHR
module icache_fill (
    input  logic                    clock,
    input  logic                    reset,
    input  icache_pkg::mem_resp_t   mem_resp,
    input  icache_pkg::mshr_entry_t head_entry,
    input  logic                    queue_empty,
    input  icache_pkg::set_idx_t    [icache_pkg::num_banks-1:0] read_set,
    output icache_pkg::line_meta_t
                                    [icache_pkg::num_banks-1:0]
                                    [icache_pkg::num_sets-1:0]  line_meta,
    output icache_pkg::block_t      [icache_pkg::num_banks-1:0] read_block,
    output logic                    fill_done
);

    // block storage, one array per bank
    icache_pkg::block_t data_mem [icache_pkg::num_banks][icache_pkg::num_sets];

    logic                 fill_bank;
    icache_pkg::set_idx_t fill_set;

    ////////////////////////////////////////////////////////////////////////////
    // response match
    ////////////////////////////////////////////////////////////////////////////

    // in-order drain, only the head tag counts
    // stale tags of abandoned misses never match
    assign fill_done = !queue_empty
                    && (mem_resp.tag != '0)
                    && (mem_resp.tag == head_entry.tag);

    assign fill_bank = icache_pkg::addr_bank(head_entry.addr);
    assign fill_set  = icache_pkg::addr_set(head_entry.addr);

    ////////////////////////////////////////////////////////////////////////////
    // arrays
    ////////////////////////////////////////////////////////////////////////////

    // metadata, all lines invalid out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            line_meta <= '0;
        end else if (fill_done) begin
            line_meta[fill_bank][fill_set] <= '{
                valid: 1'b1,
                tag:   icache_pkg::addr_tag(head_entry.addr)
            };
        end
    end

    // data written on the response edge
    always_ff @(posedge clock) begin
        if (fill_done) begin
            data_mem[fill_bank][fill_set] <= mem_resp.data;
        end
    end

    // async read like a register file
    always_comb begin
        for (int b = 0; b < icache_pkg::num_banks; b++) begin
            read_block[b] = data_mem[b][read_set[b]];
        end
    end

endmodule

/* hw/icache_miss_queue.sv */
// icache miss queue: MSHR ring, in-flight search, lowest miss pick, memory request issue
module icache_miss_queue (
    input  logic                    clock,
    input  logic                    reset,
    input  icache_pkg::addr_t       [icache_pkg::prefetch_dist-1:0] window_addr,
    input  logic                    [icache_pkg::prefetch_dist-1:0] cache_miss_window,
    input  logic                    mem_accepted,
    input  icache_pkg::mem_tag_t    mem_tag,
    input  logic                    restore,
    input  logic                    fill_done,
    output icache_pkg::mem_req_t    mem_req,
    output icache_pkg::mshr_entry_t head_entry,
    output logic                    queue_empty
);

    // MSHR payload, valid range is set by head and free count
    icache_pkg::mshr_entry_t [icache_pkg::mshr_depth-1:0] mshr_q;
    // head is the oldest, tail the next to allocate
    icache_pkg::mshr_idx_t head_q;
    icache_pkg::mshr_idx_t tail_q;
    icache_pkg::mshr_cnt_t free_q;

    logic [icache_pkg::prefetch_dist-1:0] in_flight;
    logic [icache_pkg::prefetch_dist-1:0] want;
    logic [$clog2(icache_pkg::prefetch_dist)-1:0] pick_slot;
    logic pick_valid;
    logic issue;

    ////////////////////////////////////////////////////////////////////////////
    // in-flight search
    ////////////////////////////////////////////////////////////////////////////

    // compare every window block against the occupied entries only
    always_comb begin
        icache_pkg::mshr_idx_t slot;
        in_flight = '0;
        for (int i = 0; i < icache_pkg::prefetch_dist; i++) begin
            for (int j = 0; j < icache_pkg::mshr_depth; j++) begin
                slot = head_q + icache_pkg::mshr_idx_t'(j);
                if ((j < icache_pkg::mshr_depth - int'(free_q))
                        && (mshr_q[slot].addr == icache_pkg::block_addr(window_addr[i]))) begin
                    in_flight[i] = 1'b1;
                end
            end
        end
    end

    // missing in cache and not yet requested
    assign want = cache_miss_window & ~in_flight;

    // lowest slot first, so fetch slots beat prefetch
    always_comb begin
        pick_valid = 1'b0;
        pick_slot  = '0;
        for (int i = icache_pkg::prefetch_dist - 1; i >= 0; i--) begin
            if (want[i]) begin
                pick_valid = 1'b1;
                pick_slot  = ($clog2(icache_pkg::prefetch_dist))'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request issue
    ////////////////////////////////////////////////////////////////////////////

    // re-derived every cycle, held back in reset and while no entry is free
    always_comb begin
        mem_req.valid = !reset && pick_valid && (free_q != '0);
        mem_req.prior = pick_slot < icache_pkg::fetch_width;
        mem_req.addr  = icache_pkg::block_addr(window_addr[pick_slot]);
    end

    assign issue = mem_req.valid && mem_accepted;

    // ring pointers
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q <= '0;
            tail_q <= '0;
            free_q <= icache_pkg::mshr_cnt_t'(icache_pkg::mshr_depth);
        end else begin
            tail_q <= tail_q + icache_pkg::mshr_idx_t'(issue);
            if (restore) begin
                // drop everything older than this cycle's accept
                head_q <= tail_q;
                free_q <= icache_pkg::mshr_cnt_t'(icache_pkg::mshr_depth)
                        - icache_pkg::mshr_cnt_t'(issue);
            end else begin
                head_q <= head_q + icache_pkg::mshr_idx_t'(fill_done);
                free_q <= free_q - icache_pkg::mshr_cnt_t'(issue)
                        + icache_pkg::mshr_cnt_t'(fill_done);
            end
        end
    end

    // record address and tag at the tail on accept
    always_ff @(posedge clock) begin
        if (issue) begin
            mshr_q[tail_q].addr <= mem_req.addr;
            mshr_q[tail_q].tag  <= mem_tag;
        end
    end

    assign head_entry  = mshr_q[head_q];
    assign queue_empty = (free_q == icache_pkg::mshr_cnt_t'(icache_pkg::mshr_depth));

endmodule

/* hw/icache_lookup.sv */
// icache lookup: prefetch window, tag compare, bank set select, fetch word select
module icache_lookup (
    input  icache_pkg::addr_t    [icache_pkg::fetch_width-1:0]   fetch_addr,
    input  icache_pkg::line_meta_t
                                 [icache_pkg::num_banks-1:0]
                                 [icache_pkg::num_sets-1:0]      line_meta,
    input  icache_pkg::block_t   [icache_pkg::num_banks-1:0]     read_block,
    output icache_pkg::addr_t    [icache_pkg::prefetch_dist-1:0] window_addr,
    output logic                 [icache_pkg::prefetch_dist-1:0] cache_miss_window,
    output icache_pkg::set_idx_t [icache_pkg::num_banks-1:0]     read_set,
    output icache_pkg::word_t    [icache_pkg::fetch_width-1:0]   fetch_data,
    output logic                 [icache_pkg::fetch_width-1:0]   fetch_miss
);

    // valid line in the address's bank and set with a matching tag
    function automatic logic tag_hit(icache_pkg::addr_t addr);
        icache_pkg::line_meta_t meta;
        meta = line_meta[icache_pkg::addr_bank(addr)][icache_pkg::addr_set(addr)];
        return meta.valid && (meta.tag == icache_pkg::addr_tag(addr));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // prefetch window
    ////////////////////////////////////////////////////////////////////////////

    // consecutive words from the first fetch slot
    always_comb begin
        for (int i = 0; i < icache_pkg::prefetch_dist; i++) begin
            window_addr[i] = fetch_addr[0]
                           + icache_pkg::addr_t'(i * icache_pkg::word_bytes);
        end
    end

    // miss flag per window slot, the miss queue masks in-flight blocks
    always_comb begin
        for (int i = 0; i < icache_pkg::prefetch_dist; i++) begin
            cache_miss_window[i] = !tag_hit(window_addr[i]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // fetch slots
    ////////////////////////////////////////////////////////////////////////////

    // one array read per bank
    // walk from the top so slot 0 wins a bank conflict
    always_comb begin
        read_set = '0;
        for (int i = icache_pkg::fetch_width - 1; i >= 0; i--) begin
            read_set[icache_pkg::addr_bank(fetch_addr[i])] = icache_pkg::addr_set(fetch_addr[i]);
        end
    end

    // hit needs the tag match and the bank reading this slot's set
    always_comb begin
        logic bank;
        logic word_sel;
        logic hit;
        for (int i = 0; i < icache_pkg::fetch_width; i++) begin
            bank     = icache_pkg::addr_bank(fetch_addr[i]);
            word_sel = icache_pkg::addr_word(fetch_addr[i]);
            hit      = tag_hit(fetch_addr[i])
                    && (read_set[bank] == icache_pkg::addr_set(fetch_addr[i]));
            fetch_miss[i] = !hit;
            // zero data on a miss
            if (hit) begin
                fetch_data[i] = read_block[bank][word_sel * $bits(icache_pkg::word_t)
                                                 +: $bits(icache_pkg::word_t)];
            end else begin
                fetch_data[i] = '0;
            end
        end
    end

endmodule

/* hw/icache_pkg.sv */
// icache package with geometry localparams, address field helpers, vector typedefs, packed structs
package icache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int fetch_width   = 2;
    localparam int prefetch_dist = 6;
    localparam int num_banks     = 2;
    localparam int num_sets      = 8;
    localparam int mshr_depth    = 4;

    // byte address layout
    localparam int word_bit   = 2;
    localparam int bank_bit   = 3;
    localparam int set_lsb    = 4;
    localparam int tag_lsb    = 7;
    localparam int word_bytes = 4;

    ////////////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0]            addr_t;
    typedef logic [31:0]            word_t;
    // word 0 sits in the low half
    typedef logic [63:0]            block_t;
    // tag 0 means no transaction
    typedef logic [3:0]             mem_tag_t;
    typedef logic [tag_lsb-set_lsb-1:0] set_idx_t;
    typedef logic [31-tag_lsb:0]    line_tag_t;
    typedef logic [1:0]             mshr_idx_t;
    // free entry count, 0 up to mshr_depth
    typedef logic [2:0]             mshr_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        logic  prior;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t tag;
        block_t   data;
    } mem_resp_t;

    typedef struct packed {
        addr_t    addr;
        mem_tag_t tag;
    } mshr_entry_t;

    typedef struct packed {
        logic      valid;
        line_tag_t tag;
    } line_meta_t;

    // address field extraction
    function automatic addr_t block_addr(addr_t addr);
        return {addr[31:bank_bit], {bank_bit{1'b0}}};
    endfunction

    function automatic logic addr_bank(addr_t addr);
        return addr[bank_bit];
    endfunction

    function automatic logic addr_word(addr_t addr);
        return addr[word_bit];
    endfunction

    function automatic set_idx_t addr_set(addr_t addr);
        return addr[tag_lsb-1:set_lsb];
    endfunction

    function automatic line_tag_t addr_tag(addr_t addr);
        return addr[31:tag_lsb];
    endfunction

endpackage
